// ==== rtl/a2_audio_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "a2_glue_settings.svh"

module a2_audio_mixer (
    input  logic                   clk_logic_w,
    input  logic                   rst_n_i,
    input  a2_av_pkg::card_audio_t audio_i,
    input  logic                   speaker_en_i,
    output a2_av_pkg::stereo_t     mix_o
);

    import a2_av_pkg::*;

    audio_sample_t mb_l_w;
    audio_sample_t mb_r_w;
    audio_sample_t spk_w;

    // Mockingboard samples sit 5 bits up in the mixed word
    assign mb_l_w = audio_sample_t'(audio_i.mb_l) << `A2_MB_SHIFT;
    assign mb_r_w = audio_sample_t'(audio_i.mb_r) << `A2_MB_SHIFT;

    // Speaker is a single bit worth a large step
    assign spk_w = speaker_en_i ? (audio_sample_t'(audio_i.speaker) << `A2_SPK_SHIFT)
                                : '0;

    // Sum wraps at the sample width
    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            mix_o <= '0;
        end else begin
            mix_o.l <= audio_i.ssp + mb_l_w + spk_w;
            mix_o.r <= audio_i.ssp + mb_r_w + spk_w;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/a2_av_pkg.sv ====
`default_nettype none

`include "a2_glue_settings.svh"

package a2_av_pkg;

    typedef logic [`A2_COLOR_W-1:0] color_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef logic [`A2_AUDIO_W-1:0]    audio_sample_t;
    typedef logic [`A2_MB_AUDIO_W-1:0] mb_sample_t;

    // SuperSprite, Mockingboard and speaker sources
    typedef struct packed {
        audio_sample_t ssp;
        mb_sample_t    mb_l;
        mb_sample_t    mb_r;
        logic          speaker;
    } card_audio_t;

    typedef struct packed {
        audio_sample_t l;
        audio_sample_t r;
    } stereo_t;

    typedef struct packed {
        logic                   soc_led;
        logic                   vdp_unlocked;
        logic [`A2_GMODE_W-1:0] gmode;
    } panel_status_t;

endpackage

`default_nettype wire

// ==== rtl/a2_bus_pkg.sv ====
`default_nettype none

`include "a2_glue_settings.svh"

package a2_bus_pkg;

    typedef logic [`A2_DATA_W-1:0] bus_data_t;

    // Read strobe plus the byte the card puts on the bus
    typedef struct packed {
        logic      rd;
        bus_data_t data;
    } card_rsp_t;

    typedef struct packed {
        card_rsp_t ssc;
        card_rsp_t ssp;
        card_rsp_t mb;
        card_rsp_t diskii;
        card_rsp_t cardrom;
    } card_rsps_t;

    // Active-low interrupt levels
    typedef struct packed {
        logic mb_n;
        logic vdp_n;
        logic ssc_n;
    } card_irqs_t;

    // Listed from highest to lowest priority
    typedef enum logic [2:0] {
        SRC_SSC,
        SRC_SSP,
        SRC_MB,
        SRC_DISKII,
        SRC_CARDROM,
        SRC_BUS
    } card_src_e;

endpackage

`default_nettype wire

// ==== rtl/a2_card_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "a2_glue_settings.svh"

module a2_card_merge (
    input  a2_bus_pkg::bus_data_t  bus_data_i,
    input  a2_bus_pkg::card_rsps_t rsps_i,
    input  a2_bus_pkg::card_irqs_t irqs_i,
    output logic                   data_out_en_o,
    output a2_bus_pkg::bus_data_t  data_out_o,
    output logic                   irq_n_o
);

    import a2_bus_pkg::*;

    localparam bit DATA_OUT_EN = `A2_BUS_DATA_OUT_ENABLE;
    localparam bit IRQ_OUT_EN  = `A2_IRQ_OUT_ENABLE;

    card_src_e src;
    logic      any_rd;
    logic      irq_all_n;

    // Fixed priority, SuperSerial first
    always_comb begin
        if (rsps_i.ssc.rd) begin
            src = SRC_SSC;
        end else if (rsps_i.ssp.rd) begin
            src = SRC_SSP;
        end else if (rsps_i.mb.rd) begin
            src = SRC_MB;
        end else if (rsps_i.diskii.rd) begin
            src = SRC_DISKII;
        end else if (rsps_i.cardrom.rd) begin
            src = SRC_CARDROM;
        end else begin
            src = SRC_BUS;
        end
    end

    always_comb begin
        case (src)
            SRC_SSC:     data_out_o = rsps_i.ssc.data;
            SRC_SSP:     data_out_o = rsps_i.ssp.data;
            SRC_MB:      data_out_o = rsps_i.mb.data;
            SRC_DISKII:  data_out_o = rsps_i.diskii.data;
            SRC_CARDROM: data_out_o = rsps_i.cardrom.data;
            default:     data_out_o = bus_data_i;
        endcase
    end

    assign any_rd = rsps_i.ssc.rd | rsps_i.ssp.rd | rsps_i.mb.rd
                  | rsps_i.diskii.rd | rsps_i.cardrom.rd;
    assign data_out_en_o = any_rd & DATA_OUT_EN;

    // Open-collector style wired-AND of the card interrupts
    assign irq_all_n = irqs_i.mb_n & irqs_i.vdp_n & irqs_i.ssc_n;
    assign irq_n_o   = irq_all_n | ~IRQ_OUT_EN;

endmodule

`default_nettype wire

// ==== rtl/a2_edge_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module a2_edge_sync (
    input  logic clk_logic_w,
    input  logic rst_n_i,
    input  logic async_i,
    output logic level_o,
    output logic level_n_o,
    output logic rise_o,
    output logic fall_o,
    output logic any_edge_o
);

    // Two synchronizer stages, then one flop of history for edges
    logic meta_q;
    logic sync_q;
    logic hist_q;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            meta_q <= 1'b0;
            sync_q <= 1'b0;
            hist_q <= 1'b0;
        end else begin
            meta_q <= async_i;
            sync_q <= meta_q;
            hist_q <= sync_q;
        end
    end

    assign level_o   = sync_q;
    assign level_n_o = ~sync_q;

    // High in the cycle where the synchronized level has just changed
    assign rise_o     = sync_q & ~hist_q;
    assign fall_o     = ~sync_q & hist_q;
    assign any_edge_o = rise_o | fall_o;

endmodule

`default_nettype wire

// ==== rtl/a2_front_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "a2_glue_settings.svh"

module a2_front_panel (
    input  logic                     clk_logic_w,
    input  logic                     rst_n_i,
    input  logic [3:0]               dip_switches_n_i,
    input  logic                     button_n_i,
    input  a2_av_pkg::panel_status_t status_i,
    output logic                     scanlines_o,
    output logic                     speaker_en_o,
    output logic [`A2_LED_W-1:0]     led_o
);

    localparam bit SCANLINES_FORCE = `A2_SCANLINES_ENABLE;
    localparam bit SPEAKER_FORCE   = `A2_SPEAKER_ENABLE;

    // Switches are closed when low
    assign scanlines_o  = ~dip_switches_n_i[0] | SCANLINES_FORCE;
    assign speaker_en_o = ~dip_switches_n_i[1] | SPEAKER_FORCE;

    // LEDs are lit by a low level, so reset leaves them dark
    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            led_o <= '1;
        end else if (!button_n_i) begin
            led_o <= {4'b1111, ~status_i.soc_led};
        end else begin
            led_o <= {~status_i.vdp_unlocked, ~status_i.gmode};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/a2_glue_settings.svh ====
`ifndef A2_GLUE_SETTINGS_SVH
`define A2_GLUE_SETTINGS_SVH

// Bus and video widths
`define A2_DATA_W 8
`define A2_COLOR_W 8
`define A2_GMODE_W 4
`define A2_LED_W 5

// Audio widths and alignment inside the mixed sample
`define A2_AUDIO_W 16
`define A2_MB_AUDIO_W 10
`define A2_MB_SHIFT 5
`define A2_SPK_SHIFT 13

// Forced-on features, ORed with the DIP switches
`define A2_SCANLINES_ENABLE 0
`define A2_SPEAKER_ENABLE 0

// Permission to drive the Apple bus
`define A2_BUS_DATA_OUT_ENABLE 1
`define A2_IRQ_OUT_ENABLE 1

`endif

// ==== rtl/a2_glue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "a2_glue_settings.svh"

module a2_glue_top (
    input  logic                     clk_logic_w,
    input  logic                     rst_n_i,
    input  logic                     a2_phi1_i,
    input  logic                     a2_7m_i,
    output logic                     phi0_o,
    output logic                     phi1_o,
    output logic                     phi1_rise_o,
    output logic                     phi1_fall_o,
    output logic                     clk_2m_tick_o,
    output logic                     clk_7m_o,
    output logic                     clk_7m_rise_o,
    output logic                     clk_7m_fall_o,
    output logic                     clk_14m_tick_o,
    input  a2_bus_pkg::bus_data_t    bus_data_i,
    input  a2_bus_pkg::card_rsps_t   rsps_i,
    input  a2_bus_pkg::card_irqs_t   irqs_i,
    output logic                     data_out_en_o,
    output a2_bus_pkg::bus_data_t    data_out_o,
    output logic                     irq_n_o,
    input  a2_av_pkg::card_audio_t   audio_i,
    output a2_av_pkg::stereo_t       mix_o,
    input  a2_av_pkg::rgb_t          pixel_i,
    input  logic [9:0]               screen_y_i,
    output a2_av_pkg::rgb_t          pixel_o,
    input  logic [3:0]               dip_switches_n_i,
    input  logic                     button_n_i,
    input  a2_av_pkg::panel_status_t status_i,
    output logic [`A2_LED_W-1:0]     led_o
);

    logic scanlines_w;
    logic speaker_en_w;

    // Phi1 into the logic domain; phi0 is its inverse
    a2_edge_sync u_phi1_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .async_i     (a2_phi1_i),
        .level_o     (phi1_o),
        .level_n_o   (phi0_o),
        .rise_o      (phi1_rise_o),
        .fall_o      (phi1_fall_o),
        .any_edge_o  (clk_2m_tick_o)
    );

    // 7M with both edges giving the 14M tick
    a2_edge_sync u_7m_sync (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .async_i     (a2_7m_i),
        .level_o     (clk_7m_o),
        .level_n_o   (),
        .rise_o      (clk_7m_rise_o),
        .fall_o      (clk_7m_fall_o),
        .any_edge_o  (clk_14m_tick_o)
    );

    a2_card_merge u_card_merge (
        .bus_data_i    (bus_data_i),
        .rsps_i        (rsps_i),
        .irqs_i        (irqs_i),
        .data_out_en_o (data_out_en_o),
        .data_out_o    (data_out_o),
        .irq_n_o       (irq_n_o)
    );

    a2_audio_mixer u_audio_mixer (
        .clk_logic_w  (clk_logic_w),
        .rst_n_i      (rst_n_i),
        .audio_i      (audio_i),
        .speaker_en_i (speaker_en_w),
        .mix_o        (mix_o)
    );

    a2_scanline_dimmer u_scanline_dimmer (
        .clk_logic_w (clk_logic_w),
        .rst_n_i     (rst_n_i),
        .pixel_i     (pixel_i),
        .line_odd_i  (screen_y_i[0]),
        .scanlines_i (scanlines_w),
        .pixel_o     (pixel_o)
    );

    a2_front_panel u_front_panel (
        .clk_logic_w      (clk_logic_w),
        .rst_n_i          (rst_n_i),
        .dip_switches_n_i (dip_switches_n_i),
        .button_n_i       (button_n_i),
        .status_i         (status_i),
        .scanlines_o      (scanlines_w),
        .speaker_en_o     (speaker_en_w),
        .led_o            (led_o)
    );

endmodule

`default_nettype wire

// ==== rtl/a2_scanline_dimmer.sv ====
`timescale 1ns/1ps
`default_nettype none

module a2_scanline_dimmer (
    input  logic            clk_logic_w,
    input  logic            rst_n_i,
    input  a2_av_pkg::rgb_t pixel_i,
    input  logic            line_odd_i,
    input  logic            scanlines_i,
    output a2_av_pkg::rgb_t pixel_o
);

    import a2_av_pkg::*;

    rgb_t half_w;
    logic dim_w;

    // Half brightness on every other line
    assign half_w.r = pixel_i.r >> 1;
    assign half_w.g = pixel_i.g >> 1;
    assign half_w.b = pixel_i.b >> 1;

    assign dim_w = scanlines_i & line_odd_i;

    always_ff @(posedge clk_logic_w) begin
        if (!rst_n_i) begin
            pixel_o <= '0;
        end else begin
            pixel_o <= dim_w ? half_w : pixel_i;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module a2_glue_tb -f vlog.f -o sim_a2_glue

out="$(./obj_dir/sim_a2_glue 2>&1)" || { echo "$out"; exit 1; }
echo "$out"

if grep -qF -- ">>> PASS" <<< "$out"; then
    exit 0
else
    exit 1
fi

// ==== tb/a2_glue_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module a2_glue_asserts (
    input logic clk_logic_w,
    input logic rst_n_i,
    input logic phi0_i,
    input logic phi1_i,
    input logic phi1_rise_i,
    input logic phi1_fall_i,
    input logic m7_i,
    input logic m7_rise_i,
    input logic m7_fall_i
);

    // Phi0 is derived from the synchronized phi1
    phi0_inverse: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        phi0_i == ~phi1_i)
        else $error("phi0 is not the inverse of phi1");

    phi1_one_edge: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        !(phi1_rise_i && phi1_fall_i))
        else $error("phi1 rise and fall pulses high together");

    m7_one_edge: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        !(m7_rise_i && m7_fall_i))
        else $error("7M rise and fall pulses high together");

    // A pulse marks the cycle where the level has just changed
    phi1_rise_level: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        phi1_rise_i |-> (phi1_i && !$past(phi1_i)))
        else $error("phi1 rise pulse without a level change");

    phi1_fall_level: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        phi1_fall_i |-> (!phi1_i && $past(phi1_i)))
        else $error("phi1 fall pulse without a level change");

    m7_rise_level: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        m7_rise_i |-> (m7_i && !$past(m7_i)))
        else $error("7M rise pulse without a level change");

    m7_fall_level: assert property (@(posedge clk_logic_w) disable iff (!rst_n_i)
        m7_fall_i |-> (!m7_i && $past(m7_i)))
        else $error("7M fall pulse without a level change");

endmodule

bind a2_glue_top a2_glue_asserts u_glue_asserts (
    .clk_logic_w (clk_logic_w),
    .rst_n_i     (rst_n_i),
    .phi0_i      (phi0_o),
    .phi1_i      (phi1_o),
    .phi1_rise_i (phi1_rise_o),
    .phi1_fall_i (phi1_fall_o),
    .m7_i        (clk_7m_o),
    .m7_rise_i   (clk_7m_rise_o),
    .m7_fall_i   (clk_7m_fall_o)
);

`default_nettype wire

// ==== tb/a2_glue_cases.txt ====
# C cycles | M bus rd[ssc,ssp,mb,dk,rom] d_ssc d_ssp d_mb d_dk d_rom irq[mb,vdp,ssc] exp_d en irq
# A dip ssp mb_l mb_r spk exp_l exp_r | P dip r g b y exp_r exp_g exp_b | L btn soc vdp gm exp_led
C 60
M 5A 00 11 22 33 44 55 7 5A 0 1
M 5A 1F 11 22 33 44 55 7 11 1 1
M 5A 0F 11 22 33 44 55 3 22 1 0
M 5A 07 11 22 33 44 55 6 33 1 0
M 5A 03 11 22 33 44 55 5 44 1 0
M 5A 01 11 22 33 44 55 7 55 1 1
M A5 10 11 22 33 44 55 0 11 1 0
M A5 08 11 22 33 44 55 7 22 1 1
A F 0100 003 010 1 0160 0300
A D 0100 003 010 1 2160 2300
A D FFF0 3FF 001 1 9FD0 2010
A F 1234 000 000 0 1234 1234
P E 80 41 FF 001 40 20 7F
P E 80 41 FF 002 80 41 FF
P F 80 41 FF 003 80 41 FF
P C 10 03 01 3FF 08 01 00
C 80
L 0 1 0 0 1E
L 0 0 1 F 1F
L 1 0 1 5 0A
L 1 0 0 0 1F
L 1 1 0 A 15
C 40
A D 0000 000 000 1 2000 2000

// ==== tb/a2_glue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module a2_glue_tb;

    import a2_bus_pkg::*;
    import a2_av_pkg::*;

    logic          clk_logic_w;
    logic          rst_n_i;
    logic          a2_phi1;
    logic          a2_7m;
    logic          phi0, phi1, phi1_rise, phi1_fall, tick_2m;
    logic          clk_7m, clk_7m_rise, clk_7m_fall, tick_14m;
    bus_data_t     bus_data;
    card_rsps_t    rsps;
    card_irqs_t    irqs;
    logic          data_out_en;
    bus_data_t     data_out;
    logic          irq_n;
    card_audio_t   audio;
    stereo_t       mix;
    rgb_t          pixel_in;
    rgb_t          pixel_out;
    logic [9:0]    screen_y;
    logic [3:0]    dip_n;
    logic          button_n;
    panel_status_t status;
    logic [4:0]    led;

    int fd;
    int err_cnt;
    int cycle_cnt;
    int cycle_limit;
    int seed;
    // Last three values driven on phi1 and 7M, newest first
    logic hist_phi [0:2];
    logic hist_m7 [0:2];

    a2_glue_top u_a2_glue_top (
        .clk_logic_w (clk_logic_w), .rst_n_i (rst_n_i),
        .a2_phi1_i (a2_phi1), .a2_7m_i (a2_7m),
        .phi0_o (phi0), .phi1_o (phi1), .phi1_rise_o (phi1_rise),
        .phi1_fall_o (phi1_fall), .clk_2m_tick_o (tick_2m),
        .clk_7m_o (clk_7m), .clk_7m_rise_o (clk_7m_rise),
        .clk_7m_fall_o (clk_7m_fall), .clk_14m_tick_o (tick_14m),
        .bus_data_i (bus_data), .rsps_i (rsps), .irqs_i (irqs),
        .data_out_en_o (data_out_en), .data_out_o (data_out), .irq_n_o (irq_n),
        .audio_i (audio), .mix_o (mix),
        .pixel_i (pixel_in), .screen_y_i (screen_y), .pixel_o (pixel_out),
        .dip_switches_n_i (dip_n), .button_n_i (button_n), .status_i (status),
        .led_o (led)
    );

    initial clk_logic_w = 1'b0;
    always #4 clk_logic_w = ~clk_logic_w;

    always @(posedge clk_logic_w) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic report_fail(input string msg);
        err_cnt = err_cnt + 1;
        $display("Fail at %0t ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic stop_on_file_error(input string msg);
        $display("Problem with the cases file: %s", msg);
        $display(">>> FAIL");
        $fatal(1, "Cases file unusable");
    endtask

    // Random toggles on both clocks, then a quiet tail so all edges come out
    task automatic run_clock_pattern(input int n_cycles);
        int gap_phi, gap_m7;
        int phi_up, phi_dn, m7_up, m7_dn;
        int rise_phi, fall_phi, rise_m7, fall_m7, ticks_2m, ticks_14m;
        gap_phi = 1 + ($random(seed) & 3);
        gap_m7 = 1 + ($random(seed) & 3);
        {phi_up, phi_dn, m7_up, m7_dn} = '0;
        {rise_phi, fall_phi, rise_m7, fall_m7, ticks_2m, ticks_14m} = '0;
        for (int i = 0; i < 3; i++) begin
            hist_phi[i] = a2_phi1;
            hist_m7[i] = a2_7m;
        end
        for (int i = 0; i < n_cycles + 3; i++) begin
            @(posedge clk_logic_w);
            #1;
            // Level is the value driven two cycles ago, edge is its change
            assert (phi1 === hist_phi[1] && phi0 === ~hist_phi[1]) else
                report_fail($sformatf("phi1/phi0 levels %b/%b, expected %b/%b",
                                      phi1, phi0, hist_phi[1], ~hist_phi[1]));
            assert (clk_7m === hist_m7[1]) else
                report_fail($sformatf("7M level %b, expected %b", clk_7m, hist_m7[1]));
            assert (tick_2m === (hist_phi[1] ^ hist_phi[2])) else
                report_fail($sformatf("2M tick %b, expected %b",
                                      tick_2m, hist_phi[1] ^ hist_phi[2]));
            assert (tick_14m === (hist_m7[1] ^ hist_m7[2])) else
                report_fail($sformatf("14M tick %b, expected %b",
                                      tick_14m, hist_m7[1] ^ hist_m7[2]));
            rise_phi += int'(phi1_rise);
            fall_phi += int'(phi1_fall);
            rise_m7 += int'(clk_7m_rise);
            fall_m7 += int'(clk_7m_fall);
            ticks_2m += int'(tick_2m);
            ticks_14m += int'(tick_14m);
            hist_phi[2] = hist_phi[1];
            hist_phi[1] = hist_phi[0];
            hist_m7[2] = hist_m7[1];
            hist_m7[1] = hist_m7[0];
            if (i < n_cycles) begin
                gap_phi = gap_phi - 1;
                gap_m7 = gap_m7 - 1;
                if (gap_phi == 0) begin
                    a2_phi1 = ~a2_phi1;
                    if (a2_phi1) phi_up++;
                    else phi_dn++;
                    gap_phi = 1 + ($random(seed) & 3);
                end
                if (gap_m7 == 0) begin
                    a2_7m = ~a2_7m;
                    if (a2_7m) m7_up++;
                    else m7_dn++;
                    gap_m7 = 1 + ($random(seed) & 3);
                end
            end
            hist_phi[0] = a2_phi1;
            hist_m7[0] = a2_7m;
        end
        assert (rise_phi == phi_up && fall_phi == phi_dn) else
            report_fail($sformatf("phi1 pulses %0d/%0d, transitions %0d/%0d",
                                  rise_phi, fall_phi, phi_up, phi_dn));
        assert (rise_m7 == m7_up && fall_m7 == m7_dn) else
            report_fail($sformatf("7M pulses %0d/%0d, transitions %0d/%0d",
                                  rise_m7, fall_m7, m7_up, m7_dn));
        assert (ticks_2m == phi_up + phi_dn && ticks_14m == m7_up + m7_dn) else
            report_fail($sformatf("ticks %0d/%0d do not match transitions",
                                  ticks_2m, ticks_14m));
    endtask

    task automatic check_merge();
        logic [7:0] bus, d0, d1, d2, d3, d4, exp_d;
        logic [4:0] rd;
        logic [2:0] irq_lv;
        logic       exp_en, exp_irq;
        int         n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", bus, rd, d0, d1, d2, d3, d4,
                    irq_lv, exp_d, exp_en, exp_irq);
        if (n != 11) stop_on_file_error("merge line is incomplete");
        @(posedge clk_logic_w);
        #1;
        bus_data = bus;
        rsps = {rd[4], d0, rd[3], d1, rd[2], d2, rd[1], d3, rd[0], d4};
        irqs = irq_lv;
        #1;
        assert (data_out === exp_d) else
            report_fail($sformatf("merge data %h, expected %h", data_out, exp_d));
        assert (data_out_en === exp_en) else
            report_fail($sformatf("merge enable %b, expected %b", data_out_en, exp_en));
        assert (irq_n === exp_irq) else
            report_fail($sformatf("irq_n %b, expected %b", irq_n, exp_irq));
        @(posedge clk_logic_w);
    endtask

    task automatic check_audio();
        logic [3:0]  dip;
        logic [15:0] ssp, exp_l, exp_r;
        logic [9:0]  mb_l, mb_r;
        logic        spk;
        int          n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h", dip, ssp, mb_l, mb_r, spk, exp_l, exp_r);
        if (n != 7) stop_on_file_error("audio line is incomplete");
        @(posedge clk_logic_w);
        #1;
        dip_n = dip;
        audio = {ssp, mb_l, mb_r, spk};
        @(posedge clk_logic_w);
        #1;
        assert (mix.l === exp_l && mix.r === exp_r) else
            report_fail($sformatf("mix %h/%h, expected %h/%h", mix.l, mix.r, exp_l, exp_r));
    endtask

    task automatic check_pixel();
        logic [3:0] dip;
        logic [7:0] r, g, b, er, eg, eb;
        logic [9:0] y;
        int         n;
        n = $fscanf(fd, "%h %h %h %h %h %h %h %h", dip, r, g, b, y, er, eg, eb);
        if (n != 8) stop_on_file_error("pixel line is incomplete");
        @(posedge clk_logic_w);
        #1;
        dip_n = dip;
        pixel_in = {r, g, b};
        screen_y = y;
        @(posedge clk_logic_w);
        #1;
        assert (pixel_out === {er, eg, eb}) else
            report_fail($sformatf("pixel %h, expected %h", pixel_out, {er, eg, eb}));
    endtask

    task automatic check_led();
        logic       btn, soc, vdp;
        logic [3:0] gmode;
        logic [4:0] exp_led;
        int         n;
        n = $fscanf(fd, "%h %h %h %h %h", btn, soc, vdp, gmode, exp_led);
        if (n != 5) stop_on_file_error("LED line is incomplete");
        @(posedge clk_logic_w);
        #1;
        button_n = btn;
        status = {soc, vdp, gmode};
        @(posedge clk_logic_w);
        #1;
        assert (led === exp_led) else
            report_fail($sformatf("LEDs %b, expected %b", led, exp_led));
    endtask

    initial begin
        logic [7:0]      op;
        logic [8*200-1:0] line_buf;
        int              n, cyc, total;
        {a2_phi1, a2_7m, bus_data, rsps, irqs, audio, pixel_in} = '0;
        screen_y = '0;
        dip_n = 4'hF;
        button_n = 1'b1;
        status = '0;
        rst_n_i = 1'b0;
        {err_cnt, cycle_cnt, cycle_limit, total} = '0;
        seed = 32'h79bc;
        // First pass sizes the timeout
        fd = $fopen("tb/a2_glue_cases.txt", "r");
        if (fd == 0) stop_on_file_error("cannot open tb/a2_glue_cases.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) break;
            if (op == "C") begin
                n = $fscanf(fd, "%d", cyc);
                total += cyc + 3;
            end else if (op != "#") begin
                total += 2;
            end
            n = $fgets(line_buf, fd);
        end
        $fclose(fd);
        cycle_limit = 4 * total + 100;
        repeat (4) @(posedge clk_logic_w);
        #1;
        assert (led === 5'h1F && mix === '0 && pixel_out === '0) else
            report_fail("registered outputs are not at their reset values");
        assert (phi0 === 1'b1 && phi1 === 1'b0 && clk_7m === 1'b0) else
            report_fail("clock sync levels are not at their reset values");
        assert ({phi1_rise, phi1_fall, tick_2m, clk_7m_rise, clk_7m_fall, tick_14m} === 6'b0)
            else report_fail("edge pulses are not low during reset");
        rst_n_i = 1'b1;
        fd = $fopen("tb/a2_glue_cases.txt", "r");
        if (fd == 0) stop_on_file_error("cannot reopen tb/a2_glue_cases.txt");
        while (!$feof(fd)) begin
            n = $fscanf(fd, " %c", op);
            if (n != 1) break;
            case (op)
                "#": n = $fgets(line_buf, fd);
                "C": begin
                    n = $fscanf(fd, "%d", cyc);
                    run_clock_pattern(cyc);
                end
                "M": check_merge();
                "A": check_audio();
                "P": check_pixel();
                "L": check_led();
                default: stop_on_file_error($sformatf("unknown opcode %c", op));
            endcase
        end
        $fclose(fd);
        repeat (2) @(posedge clk_logic_w);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/a2_bus_pkg.sv
rtl/a2_av_pkg.sv
rtl/a2_edge_sync.sv
rtl/a2_card_merge.sv
rtl/a2_audio_mixer.sv
rtl/a2_scanline_dimmer.sv
rtl/a2_front_panel.sv
rtl/a2_glue_top.sv
tb/a2_glue_asserts.sv
tb/a2_glue_tb.sv
